// File: common/io_control_config.svh
// Register select codes and buffer sizes for the memory-mapped I/O block
// Include in any file that decodes the bus address or sizes the SD buffer
`ifndef IO_CONTROL_CONFIG_SVH
`define IO_CONTROL_CONFIG_SVH

////////////////////////////////////////////////////////////
// Address decode
////////////////////////////////////////////////////////////

// Select field is hardware_addr[6:0]
`define IO_SEL_WIDTH 7

// Console port
`define SEL_CHAR 7'd0
`define SEL_CONSOLE_CONTROL 7'd9

// SD card port
`define SEL_SD_LBA 7'd1
`define SEL_SD_CONTROL 7'd2
`define SEL_SD_DATA 7'd3

// Status word, half picked by one address bit above the select field
`define SEL_STATUS 7'd4
`define STATUS_HALF_BIT 7

////////////////////////////////////////////////////////////
// Sector buffer, 512 bytes
////////////////////////////////////////////////////////////

`define SD_BUFF_HALFWORDS 256
`define SD_BUFF_WORDS 128

`endif

// File: common/io_control_pkg.sv
// Shared types for the I/O block and its testbench
// Referenced by scoped name, io_control_pkg::type_name
`include "io_control_config.svh"

package io_control_pkg;

	// CPU bus
	typedef logic [27:0] bus_addr_t;
	typedef logic [31:0] bus_word_t;

	// Console character code
	typedef logic [7:0] console_char_t;

	// 64-bit status input, read as two bus words
	typedef logic [63:0] status_word_t;

	////////////////////////////////////////////////////////////
	// Sector buffer
	////////////////////////////////////////////////////////////

	// SD host side, 16-bit words
	typedef logic [15:0] sd_half_t;
	typedef logic [$clog2(`SD_BUFF_HALFWORDS)-1:0] sd_half_index_t;

	// CPU side, 32-bit words
	typedef logic [$clog2(`SD_BUFF_WORDS)-1:0] sd_word_index_t;

endpackage

// File: sd_card/sd_buffer_ram.sv
// Dual-port 512-byte sector buffer with a 16-bit host port and a 32-bit CPU port
// Word k spans halfwords 2k (low) and 2k+1 (high); both reads are registered
`include "io_control_config.svh"

module sd_buffer_ram (
	input  logic                           system_clock,
	input  io_control_pkg::sd_half_index_t half_addr,
	input  io_control_pkg::sd_half_t       half_data,
	input  logic                           half_write,
	output io_control_pkg::sd_half_t       half_q,
	input  io_control_pkg::sd_word_index_t word_addr,
	input  io_control_pkg::bus_word_t      word_data,
	input  logic                           word_write,
	output io_control_pkg::bus_word_t      word_q
);

	// Bank 0 holds even halfwords and bank 1 the odd ones
	io_control_pkg::sd_half_t bank_mem [2][`SD_BUFF_WORDS];

	always_ff @(posedge system_clock) begin
		for (int bank = 0; bank < 2; bank++) begin
			// CPU word covers the same row in both banks
			if (word_write) begin
				bank_mem[bank][word_addr] <= word_data[bank*16 +: 16];
			end
			// Host halfword goes to the bank picked by its lowest address bit
			if (half_write && half_addr[0] == 1'(bank)) begin
				bank_mem[bank][half_addr[7:1]] <= half_data;
			end
		end
		half_q <= bank_mem[half_addr[0]][half_addr[7:1]];
		// Odd bank forms the upper half of the CPU word
		word_q <= {bank_mem[1][word_addr], bank_mem[0][word_addr]};
	end

endmodule

// File: sd_card/sd_card_port.sv
// SD card port: LBA and command registers, done flag and sector buffer access
// CPU moves the sector as 128 words; the SD host streams it as 256 halfwords
`include "io_control_config.svh"

module sd_card_port (
	input  logic                           system_clock,
	input  logic                           hardware_reset,
	input  io_control_pkg::bus_addr_t      hardware_addr,
	input  io_control_pkg::bus_word_t      hardware_data_in,
	input  logic                           hardware_write,
	input  logic                           hardware_ready,
	input  logic                           sd_ack,
	input  io_control_pkg::sd_half_index_t sd_buff_addr,
	input  io_control_pkg::sd_half_t       sd_buff_dout,
	input  logic                           sd_buff_wr,
	output logic                           ack,
	output io_control_pkg::bus_word_t      read_data,
	output io_control_pkg::bus_word_t      sd_lba,
	output logic                           sd_rd,
	output logic                           sd_wr,
	output io_control_pkg::sd_half_t       sd_buff_din
);

	logic                           sel_lba;
	logic                           sel_control;
	logic                           sel_data;
	logic                           accept;
	logic                           start_cmd;
	logic                           word_write;
	logic                           sd_done;
	io_control_pkg::sd_word_index_t word_index;
	io_control_pkg::bus_word_t      word_q;

	// Address decode
	assign sel_lba     = hardware_addr[`IO_SEL_WIDTH-1:0] == `SEL_SD_LBA;
	assign sel_control = hardware_addr[`IO_SEL_WIDTH-1:0] == `SEL_SD_CONTROL;
	assign sel_data    = hardware_addr[`IO_SEL_WIDTH-1:0] == `SEL_SD_DATA;

	// Data register stalls the bus until the host transfer is done
	assign accept = hardware_ready & ~ack &
		(sel_lba | sel_control | (sel_data & sd_done));

	// Command only taken when idle; read bit has priority
	assign start_cmd = accept & sel_control & hardware_write & sd_done &
		(hardware_data_in[0] | hardware_data_in[1]);

	// CPU word lands in the buffer on the accepting edge
	assign word_write = accept & sel_data & hardware_write;

	////////////////////////////////////////////////////////////
	// Command, done and word index
	////////////////////////////////////////////////////////////

	always_ff @(posedge system_clock or negedge hardware_reset) begin
		if (!hardware_reset) begin
			ack        <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_done    <= 1'b1;
			word_index <= '0;
		end else begin
			// Host has picked up the command
			if (sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
				// Last halfword of the sector
				if (sd_buff_addr == io_control_pkg::sd_half_index_t'(`SD_BUFF_HALFWORDS - 1)) begin
					sd_done <= 1'b1;
				end
			end
			if (!hardware_ready) begin
				ack <= 1'b0;
			end else if (accept) begin
				ack <= 1'b1;
			end
			if (accept && sel_lba && hardware_write) begin
				sd_lba <= hardware_data_in;
			end
			if (start_cmd) begin
				sd_rd      <= hardware_data_in[0];
				sd_wr      <= ~hardware_data_in[0];
				sd_done    <= 1'b0;
				word_index <= '0;
			end
			// Step through the sector, parking on the last word
			if (accept && sel_data && word_index != '1) begin
				word_index <= word_index + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read data
	////////////////////////////////////////////////////////////

	always_ff @(posedge system_clock) begin
		if (accept && !hardware_write) begin
			if (sel_lba) begin
				read_data <= sd_lba;
			end else if (sel_control) begin
				read_data <= {28'd0, sd_done, sd_ack, sd_wr, sd_rd};
			end else begin
				// Buffer output already tracks word_index
				read_data <= word_q;
			end
		end
	end

	// Sector buffer, host side on port A and CPU side on port B
	sd_buffer_ram u_sd_buffer_ram (
		.system_clock (system_clock),
		.half_addr    (sd_buff_addr),
		.half_data    (sd_buff_dout),
		.half_write   (sd_buff_wr & sd_ack),
		.half_q       (sd_buff_din),
		.word_addr    (word_index),
		.word_data    (hardware_data_in),
		.word_write   (word_write),
		.word_q       (word_q)
	);

endmodule

// File: console/console_port.sv
// Text console port: character register and console control register
// Strobes toward the video side hold until the console reports char_done
`include "io_control_config.svh"

module console_port (
	input  logic                          system_clock,
	input  logic                          hardware_reset,
	input  io_control_pkg::bus_addr_t     hardware_addr,
	input  io_control_pkg::bus_word_t     hardware_data_in,
	input  logic                          hardware_write,
	input  logic                          hardware_ready,
	input  logic                          char_done,
	output logic                          ack,
	output io_control_pkg::bus_word_t     read_data,
	output logic                          char_display_on,
	output logic                          char_write,
	output io_control_pkg::console_char_t char_out,
	output logic                          char_clear,
	output logic                          char_clear_line
);

	logic sel_char;
	logic sel_control;
	logic accept;

	// Address decode
	assign sel_char    = hardware_addr[`IO_SEL_WIDTH-1:0] == `SEL_CHAR;
	assign sel_control = hardware_addr[`IO_SEL_WIDTH-1:0] == `SEL_CONSOLE_CONTROL;

	// First cycle of a transfer aimed at this port
	assign accept = hardware_ready & ~ack & (sel_char | sel_control);

	////////////////////////////////////////////////////////////
	// Handshake and console control state
	////////////////////////////////////////////////////////////

	always_ff @(posedge system_clock or negedge hardware_reset) begin
		if (!hardware_reset) begin
			ack             <= 1'b0;
			char_display_on <= 1'b0;
			char_write      <= 1'b0;
			char_clear      <= 1'b0;
			char_clear_line <= 1'b0;
		end else begin
			// Console finished the pending operation
			if (char_done) begin
				char_write      <= 1'b0;
				char_clear      <= 1'b0;
				char_clear_line <= 1'b0;
			end
			// Ack holds while the master keeps ready up
			if (!hardware_ready) begin
				ack <= 1'b0;
			end else if (accept) begin
				ack <= 1'b1;
			end
			if (accept && hardware_write) begin
				if (sel_char) begin
					char_write <= 1'b1;
				end
				if (sel_control) begin
					// Bit 0 is the display enable level
					char_display_on <= hardware_data_in[0];
					// Full clear wins over line clear
					if (hardware_data_in[1]) begin
						char_clear <= 1'b1;
					end else if (hardware_data_in[2]) begin
						char_clear_line <= 1'b1;
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Character and read data
	////////////////////////////////////////////////////////////

	always_ff @(posedge system_clock) begin
		// A new write overwrites a character still pending
		if (accept && hardware_write && sel_char) begin
			char_out <= hardware_data_in[7:0];
		end
		if (accept && !hardware_write) begin
			if (sel_char) begin
				read_data <= {24'd0, char_out};
			end else begin
				read_data <= {29'd0, char_clear_line, char_clear, char_display_on};
			end
		end
	end

endmodule

// File: design/status_port.sv
// Read-only status port; address bit 7 picks the low or high half of the status word
// Writes to this select are acked and dropped
`include "io_control_config.svh"

module status_port (
	input  logic                         system_clock,
	input  logic                         hardware_reset,
	input  io_control_pkg::bus_addr_t    hardware_addr,
	input  logic                         hardware_ready,
	input  io_control_pkg::status_word_t status,
	output logic                         ack,
	output io_control_pkg::bus_word_t    read_data
);

	logic accept;

	assign accept = hardware_ready & ~ack &
		(hardware_addr[`IO_SEL_WIDTH-1:0] == `SEL_STATUS);

	always_ff @(posedge system_clock or negedge hardware_reset) begin
		if (!hardware_reset) begin
			ack <= 1'b0;
		end else if (!hardware_ready) begin
			ack <= 1'b0;
		end else if (accept) begin
			ack <= 1'b1;
		end
	end

	// Sample the requested half on the accepting edge
	always_ff @(posedge system_clock) begin
		if (accept) begin
			read_data <= hardware_addr[`STATUS_HALF_BIT] ? status[63:32] : status[31:0];
		end
	end

endmodule

// File: design/io_control.sv
// Memory-mapped I/O block for the CPU bus: console, status word and SD card ports
// One bus master; each port acks its own selects and the responses merge here
module io_control (
	input  logic                              system_clock,
	input  logic                              hardware_reset,
	// CPU bus
	input  io_control_pkg::bus_addr_t         hardware_addr,
	input  io_control_pkg::bus_word_t         hardware_data_in,
	output io_control_pkg::bus_word_t         hardware_data_out,
	input  logic                              hardware_write,
	input  logic                              hardware_ready,
	output logic                              hardware_ack,
	// Text console
	output logic                              char_display_on,
	output logic                              char_write,
	output io_control_pkg::console_char_t     char_out,
	output logic                              char_clear,
	output logic                              char_clear_line,
	input  logic                              char_done,
	// Status
	input  io_control_pkg::status_word_t      status,
	// SD host
	output io_control_pkg::bus_word_t         sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	input  logic                              sd_ack,
	input  io_control_pkg::sd_half_index_t    sd_buff_addr,
	input  io_control_pkg::sd_half_t          sd_buff_dout,
	output io_control_pkg::sd_half_t          sd_buff_din,
	input  logic                              sd_buff_wr
);

	// Per-port responses
	logic                      console_ack;
	logic                      status_ack;
	logic                      sd_port_ack;
	io_control_pkg::bus_word_t console_data;
	io_control_pkg::bus_word_t status_data;
	io_control_pkg::bus_word_t sd_port_data;

	// Selects are disjoint, so at most one port acks at a time
	assign hardware_ack = console_ack | status_ack | sd_port_ack;
	assign hardware_data_out = console_ack ? console_data :
		status_ack ? status_data :
		sd_port_ack ? sd_port_data :
		'0;

	console_port u_console_port (
		.system_clock     (system_clock),
		.hardware_reset   (hardware_reset),
		.hardware_addr    (hardware_addr),
		.hardware_data_in (hardware_data_in),
		.hardware_write   (hardware_write),
		.hardware_ready   (hardware_ready),
		.char_done        (char_done),
		.ack              (console_ack),
		.read_data        (console_data),
		.char_display_on  (char_display_on),
		.char_write       (char_write),
		.char_out         (char_out),
		.char_clear       (char_clear),
		.char_clear_line  (char_clear_line)
	);

	status_port u_status_port (
		.system_clock   (system_clock),
		.hardware_reset (hardware_reset),
		.hardware_addr  (hardware_addr),
		.hardware_ready (hardware_ready),
		.status         (status),
		.ack            (status_ack),
		.read_data      (status_data)
	);

	sd_card_port u_sd_card_port (
		.system_clock     (system_clock),
		.hardware_reset   (hardware_reset),
		.hardware_addr    (hardware_addr),
		.hardware_data_in (hardware_data_in),
		.hardware_write   (hardware_write),
		.hardware_ready   (hardware_ready),
		.sd_ack           (sd_ack),
		.sd_buff_addr     (sd_buff_addr),
		.sd_buff_dout     (sd_buff_dout),
		.sd_buff_wr       (sd_buff_wr),
		.ack              (sd_port_ack),
		.read_data        (sd_port_data),
		.sd_lba           (sd_lba),
		.sd_rd            (sd_rd),
		.sd_wr            (sd_wr),
		.sd_buff_din      (sd_buff_din)
	);

endmodule

// File: tests/sd_host_model.sv
// Behavioral SD host for the I/O block testbench
// Answers sd_rd by filling the sector buffer and sd_wr by streaming it out
`include "io_control_config.svh"

module sd_host_model #(
	parameter int unsigned SEED = 32'h634e_2099
) (
	input  logic                           system_clock,
	input  logic                           hardware_reset,
	input  io_control_pkg::bus_word_t      sd_lba,
	input  logic                           sd_rd,
	input  logic                           sd_wr,
	input  io_control_pkg::sd_half_t       sd_buff_din,
	output logic                           sd_ack,
	output io_control_pkg::sd_half_index_t sd_buff_addr,
	output io_control_pkg::sd_half_t       sd_buff_dout,
	output logic                           sd_buff_wr
);
	timeunit 1ns;
	timeprecision 1ps;

	// Sector contents seen by the host, read back by the testbench
	io_control_pkg::sd_half_t  fill_data [`SD_BUFF_HALFWORDS];
	io_control_pkg::sd_half_t  capture_data [`SD_BUFF_HALFWORDS];
	io_control_pkg::bus_word_t seen_lba;
	int                        read_commands;
	int                        write_commands;

	logic                     busy;
	logic                     is_read;
	int                       step;
	integer                   seed;
	io_control_pkg::sd_half_t next_half;

	initial begin
		seed = SEED;
		sd_ack = 1'b0;
		sd_buff_wr = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		busy = 1'b0;
		is_read = 1'b0;
		step = 0;
		seen_lba = '0;
		read_commands = 0;
		write_commands = 0;
		forever begin
			@(posedge system_clock);
			if (!hardware_reset) begin
				sd_ack <= 1'b0;
				sd_buff_wr <= 1'b0;
				busy <= 1'b0;
			end else if (!busy) begin
				// Idle until the port raises a command
				if (sd_rd || sd_wr) begin
					busy <= 1'b1;
					is_read <= sd_rd;
					step <= 0;
					seen_lba <= sd_lba;
					if (sd_rd) begin
						read_commands <= read_commands + 1;
					end else begin
						write_commands <= write_commands + 1;
					end
				end
			end else begin
				if (step < `SD_BUFF_HALFWORDS) begin
					// One halfword per cycle, ack held for the whole sector
					sd_ack <= 1'b1;
					sd_buff_addr <= io_control_pkg::sd_half_index_t'(step);
					sd_buff_wr <= is_read;
					if (is_read) begin
						next_half = io_control_pkg::sd_half_t'($random(seed));
						sd_buff_dout <= next_half;
						fill_data[step] <= next_half;
					end
				end else begin
					sd_ack <= 1'b0;
					sd_buff_wr <= 1'b0;
				end
				// Registered buffer read lands two edges after its address
				if (!is_read && step >= 2) begin
					capture_data[step - 2] <= sd_buff_din;
				end
				if (step == `SD_BUFF_HALFWORDS + 1) begin
					busy <= 1'b0;
				end
				step <= step + 1;
			end
		end
	end

endmodule

// File: tests/io_control_tb.sv
// Directed testbench for the I/O block: console, status and SD card ports
// Drives the CPU bus handshake and checks each response against the register map
`include "io_control_config.svh"

module io_control_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int BUS_TIMEOUT = 50;
	localparam int POLL_LIMIT = 200;

	logic                           system_clock;
	logic                           hardware_reset;
	io_control_pkg::bus_addr_t      hardware_addr;
	io_control_pkg::bus_word_t      hardware_data_in;
	io_control_pkg::bus_word_t      hardware_data_out;
	logic                           hardware_write;
	logic                           hardware_ready;
	logic                           hardware_ack;
	logic                           char_display_on;
	logic                           char_write;
	io_control_pkg::console_char_t  char_out;
	logic                           char_clear;
	logic                           char_clear_line;
	logic                           char_done;
	io_control_pkg::status_word_t   status;
	io_control_pkg::bus_word_t      sd_lba;
	logic                           sd_rd;
	logic                           sd_wr;
	logic                           sd_ack;
	io_control_pkg::sd_half_index_t sd_buff_addr;
	io_control_pkg::sd_half_t       sd_buff_dout;
	io_control_pkg::sd_half_t       sd_buff_din;
	logic                           sd_buff_wr;

	int                        error_count;
	int                        check_count;
	integer                    seed;
	io_control_pkg::bus_word_t lba_value;
	io_control_pkg::bus_word_t sector_words [`SD_BUFF_WORDS];

	io_control u_dut (
		.system_clock      (system_clock),
		.hardware_reset    (hardware_reset),
		.hardware_addr     (hardware_addr),
		.hardware_data_in  (hardware_data_in),
		.hardware_data_out (hardware_data_out),
		.hardware_write    (hardware_write),
		.hardware_ready    (hardware_ready),
		.hardware_ack      (hardware_ack),
		.char_display_on   (char_display_on),
		.char_write        (char_write),
		.char_out          (char_out),
		.char_clear        (char_clear),
		.char_clear_line   (char_clear_line),
		.char_done         (char_done),
		.status            (status),
		.sd_lba            (sd_lba),
		.sd_rd             (sd_rd),
		.sd_wr             (sd_wr),
		.sd_ack            (sd_ack),
		.sd_buff_addr      (sd_buff_addr),
		.sd_buff_dout      (sd_buff_dout),
		.sd_buff_din       (sd_buff_din),
		.sd_buff_wr        (sd_buff_wr)
	);

	sd_host_model #(.SEED(32'h634e_2099)) u_sd_host (
		.system_clock   (system_clock),
		.hardware_reset (hardware_reset),
		.sd_lba         (sd_lba),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.sd_buff_din    (sd_buff_din),
		.sd_ack         (sd_ack),
		.sd_buff_addr   (sd_buff_addr),
		.sd_buff_dout   (sd_buff_dout),
		.sd_buff_wr     (sd_buff_wr)
	);

	initial begin
		system_clock = 1'b0;
		forever #10 system_clock = ~system_clock;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input io_control_pkg::bus_word_t actual,
			input io_control_pkg::bus_word_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic check_char(input string name, input io_control_pkg::console_char_t actual,
			input io_control_pkg::console_char_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus handshake
	////////////////////////////////////////////////////////////

	function automatic io_control_pkg::bus_addr_t addr_of(input logic [`IO_SEL_WIDTH-1:0] sel);
		addr_of = '0;
		addr_of[`IO_SEL_WIDTH-1:0] = sel;
	endfunction

	// Raise ready, wait for ack, then drop ready and wait for ack to clear
	task automatic run_transfer(input io_control_pkg::bus_addr_t addr, input logic write,
			input io_control_pkg::bus_word_t wdata, output io_control_pkg::bus_word_t rdata);
		int cycles;
		rdata = '0;
		cycles = 0;
		@(posedge system_clock);
		hardware_addr <= addr;
		hardware_write <= write;
		hardware_data_in <= wdata;
		hardware_ready <= 1'b1;
		while (hardware_ack !== 1'b1 && cycles < BUS_TIMEOUT) begin
			@(posedge system_clock);
			cycles++;
		end
		if (hardware_ack !== 1'b1) begin
			error_count++;
			$display("Bus transfer to address 0x%h got no ack within %0d cycles", addr, cycles);
		end
		// Read data is valid while ack is high
		rdata = hardware_data_out;
		hardware_ready <= 1'b0;
		cycles = 0;
		while (hardware_ack !== 1'b0 && cycles < BUS_TIMEOUT) begin
			@(posedge system_clock);
			cycles++;
		end
		if (hardware_ack !== 1'b0) begin
			error_count++;
			$display("Ack for address 0x%h stayed high after ready dropped", addr);
		end
	endtask

	task automatic bus_write(input io_control_pkg::bus_addr_t addr,
			input io_control_pkg::bus_word_t data);
		io_control_pkg::bus_word_t unused;
		run_transfer(addr, 1'b1, data, unused);
	endtask

	task automatic bus_read(input io_control_pkg::bus_addr_t addr,
			output io_control_pkg::bus_word_t data);
		run_transfer(addr, 1'b0, '0, data);
	endtask

	// Unmapped selects must leave the master waiting
	task automatic check_no_ack(input io_control_pkg::bus_addr_t addr);
		logic acked;
		acked = 1'b0;
		@(posedge system_clock);
		hardware_addr <= addr;
		hardware_write <= 1'b0;
		hardware_ready <= 1'b1;
		for (int i = 0; i < BUS_TIMEOUT; i++) begin
			@(posedge system_clock);
			if (hardware_ack) begin
				acked = 1'b1;
			end
		end
		hardware_ready <= 1'b0;
		@(posedge system_clock);
		@(posedge system_clock);
		check_count++;
		if (acked) begin
			error_count++;
			$display("Read of unmapped address 0x%h was acked", addr);
		end
	endtask

	// One-cycle char_done; strobes read low on return
	task automatic pulse_char_done();
		@(posedge system_clock);
		char_done <= 1'b1;
		@(posedge system_clock);
		char_done <= 1'b0;
		@(posedge system_clock);
	endtask

	// Poll SD control until the done bit is back
	task automatic wait_sd_done();
		io_control_pkg::bus_word_t control;
		int polls;
		polls = 0;
		control = '0;
		while (control[3] !== 1'b1 && polls < POLL_LIMIT) begin
			bus_read(addr_of(`SEL_SD_CONTROL), control);
			polls++;
		end
		if (control[3] !== 1'b1) begin
			error_count++;
			$display("SD transfer did not finish within %0d control polls", polls);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		io_control_pkg::bus_word_t control;
		check_bit("hardware_ack", hardware_ack, 1'b0);
		check_bit("char_write", char_write, 1'b0);
		check_bit("char_clear", char_clear, 1'b0);
		check_bit("char_clear_line", char_clear_line, 1'b0);
		check_bit("char_display_on", char_display_on, 1'b0);
		check_bit("sd_rd", sd_rd, 1'b0);
		check_bit("sd_wr", sd_wr, 1'b0);
		check_word("sd_lba", sd_lba, 32'd0);
		// Idle port: only done is set
		bus_read(addr_of(`SEL_SD_CONTROL), control);
		check_word("sd control after reset", control, 32'h0000_0008);
	endtask

	task automatic test_console_char();
		io_control_pkg::console_char_t ch;
		io_control_pkg::bus_word_t     rdata;
		ch = io_control_pkg::console_char_t'($random(seed));
		// Upper bits of the bus word are not part of the character
		bus_write(addr_of(`SEL_CHAR), {24'ha5c3e1, ch});
		check_char("char_out", char_out, ch);
		check_bit("char_write", char_write, 1'b1);
		repeat (5) @(posedge system_clock);
		check_bit("char_write held", char_write, 1'b1);
		pulse_char_done();
		check_bit("char_write after char_done", char_write, 1'b0);
		bus_read(addr_of(`SEL_CHAR), rdata);
		check_word("char register read", rdata, {24'd0, ch});
	endtask

	task automatic test_console_control();
		io_control_pkg::bus_word_t rdata;
		// Display on plus full clear
		bus_write(addr_of(`SEL_CONSOLE_CONTROL), 32'h3);
		check_bit("char_display_on", char_display_on, 1'b1);
		check_bit("char_clear", char_clear, 1'b1);
		check_bit("char_clear_line", char_clear_line, 1'b0);
		check_bit("char_write", char_write, 1'b0);
		bus_read(addr_of(`SEL_CONSOLE_CONTROL), rdata);
		check_word("console control read", rdata, {29'd0, 1'b0, 1'b1, 1'b1});
		pulse_char_done();
		check_bit("char_clear after char_done", char_clear, 1'b0);
		// Line clear alone, display bit low
		bus_write(addr_of(`SEL_CONSOLE_CONTROL), 32'h4);
		check_bit("char_clear_line", char_clear_line, 1'b1);
		check_bit("char_clear", char_clear, 1'b0);
		check_bit("char_display_on", char_display_on, 1'b0);
		bus_read(addr_of(`SEL_CONSOLE_CONTROL), rdata);
		check_word("console control read", rdata, {29'd0, 1'b1, 1'b0, 1'b0});
		pulse_char_done();
		check_bit("char_clear_line after char_done", char_clear_line, 1'b0);
		check_no_ack(addr_of(7'd5));
	endtask

	task automatic test_status();
		io_control_pkg::status_word_t value;
		io_control_pkg::bus_word_t    rdata;
		value = {$random(seed), $random(seed)};
		@(posedge system_clock);
		status <= value;
		bus_read(addr_of(`SEL_STATUS), rdata);
		check_word("status low half", rdata, value[31:0]);
		bus_read(addr_of(`SEL_STATUS) | (28'd1 << `STATUS_HALF_BIT), rdata);
		check_word("status high half", rdata, value[63:32]);
	endtask

	task automatic test_sd_write();
		io_control_pkg::bus_word_t rdata;
		lba_value = $random(seed);
		bus_write(addr_of(`SEL_SD_LBA), lba_value);
		bus_read(addr_of(`SEL_SD_LBA), rdata);
		check_word("sd lba read", rdata, lba_value);
		check_word("sd_lba", sd_lba, lba_value);
		// Fill the sector from the CPU side, then hand it to the host
		for (int k = 0; k < `SD_BUFF_WORDS; k++) begin
			sector_words[k] = $random(seed);
			bus_write(addr_of(`SEL_SD_DATA), sector_words[k]);
		end
		bus_write(addr_of(`SEL_SD_CONTROL), 32'h2);
		wait_sd_done();
		check_bit("sd_wr after done", sd_wr, 1'b0);
		check_word("host write commands", io_control_pkg::bus_word_t'(u_sd_host.write_commands),
			32'd1);
		check_word("host lba", u_sd_host.seen_lba, lba_value);
		// Low half at 2k, high half at 2k+1
		for (int k = 0; k < `SD_BUFF_WORDS; k++) begin
			check_word($sformatf("host sector word %0d", k),
				{u_sd_host.capture_data[2*k+1], u_sd_host.capture_data[2*k]}, sector_words[k]);
		end
	endtask

	task automatic test_sd_read();
		io_control_pkg::bus_word_t rdata;
		bus_write(addr_of(`SEL_SD_CONTROL), 32'h1);
		wait_sd_done();
		check_bit("sd_rd after done", sd_rd, 1'b0);
		check_word("host read commands", io_control_pkg::bus_word_t'(u_sd_host.read_commands),
			32'd1);
		check_word("host lba", u_sd_host.seen_lba, lba_value);
		for (int k = 0; k < `SD_BUFF_WORDS; k++) begin
			bus_read(addr_of(`SEL_SD_DATA), rdata);
			check_word($sformatf("sector read word %0d", k), rdata,
				{u_sd_host.fill_data[2*k+1], u_sd_host.fill_data[2*k]});
		end
	endtask

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial begin
		seed = 32'h634e_2099;
		error_count = 0;
		check_count = 0;
		lba_value = '0;
		hardware_reset = 1'b0;
		hardware_addr = '0;
		hardware_data_in = '0;
		hardware_write = 1'b0;
		hardware_ready = 1'b0;
		char_done = 1'b0;
		status = '0;
		repeat (8) @(posedge system_clock);
		hardware_reset <= 1'b1;
		@(posedge system_clock);
		@(posedge system_clock);
		test_reset_state();
		test_console_char();
		test_console_control();
		test_status();
		test_sd_write();
		test_sd_read();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: io_control.f
+incdir+common
common/io_control_pkg.sv
sd_card/sd_buffer_ram.sv
sd_card/sd_card_port.sv
console/console_port.sv
design/status_port.sv
design/io_control.sv
tests/sd_host_model.sv
tests/io_control_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module io_control_tb \
		-f io_control.f -Mdir obj_dir
	@out="$$(./obj_dir/Vio_control_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
